/* verif/clock_input.txt */
# load set_h set_m set_s wait_s exp_h exp_m exp_s
# set fields and wait in decimal, expected readout as bcd hex
1 0 5 6 0 00 05 06
1 9 6 5 0 09 06 05
1 10 7 8 0 10 07 08
1 19 8 7 0 19 08 07
1 23 9 9 0 23 09 09
1 0 15 49 0 00 15 49
1 9 49 15 0 09 49 15
1 19 59 59 0 19 59 59
1 12 34 56 5 12 35 01
1 10 59 58 3 11 00 01
0 0 0 0 0 11 00 01
1 23 59 59 1 00 00 00
0 0 0 0 0 00 00 00
1 15 57 34 2 15 57 36

/* clock_top.f */
verilog/clock_pkg.sv
verilog/time_counter.sv
verilog/bin_to_bcd.sv
verilog/digit_scan.sv
verilog/seg_decode.sv
verilog/clock_top.sv
verif/tb_clock_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the clock core testbench with Verilator, runs it, checks the log
set -u

cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --timing --assert -Wno-fatal -f clock_top.f \
	--top-module tb_clock_top -o sim_clock_top; then
	echo "verilator build failed"
	exit 1
fi

if ! ./obj_dir/sim_clock_top > "$log" 2>&1; then
	cat "$log"
	echo "simulation exited with an error"
	exit 1
fi

cat "$log"

if grep -q "Simulation finished: PASS" "$log"; then
	exit 0
else
	exit 1
fi

/* verif/tb_clock_top.sv */
/*
  testbench for the 24-hour clock core
  steps come from verif/clock_input.txt, read relative to the project root
  inputs change 1 ns after the rising edge, outputs are checked there too
  stops at the first error
*/

`timescale 1ns/1ps

module tb_clock_top;

	logic            clk;
	logic            rst_n;
	logic            set_en;
	clock_pkg::bin_t set_hours;
	clock_pkg::bin_t set_minutes;
	clock_pkg::bin_t set_seconds;
	clock_pkg::bcd_t hour;
	clock_pkg::bcd_t minute;
	clock_pkg::bcd_t second;
	clock_pkg::sel_t sel;
	clock_pkg::seg_t seg;

	// one entry per data line
	int              load_q[$];
	int              wait_q[$];
	logic [7:0]      set_h_q[$];
	logic [7:0]      set_m_q[$];
	logic [7:0]      set_s_q[$];
	logic [7:0]      exp_h_q[$];
	logic [7:0]      exp_m_q[$];
	logic [7:0]      exp_s_q[$];

	int              fd;
	string           line;
	int              ld, sh, sm, ss, nw, eh, em, es;
	int              cycle_count = 0;
	int              cycle_limit = 0;
	int              steps_run = 0;

	clock_top u_dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.set_en      (set_en),
		.set_hours   (set_hours),
		.set_minutes (set_minutes),
		.set_seconds (set_seconds),
		.hour        (hour),
		.minute      (minute),
		.second      (second),
		.sel         (sel),
		.seg         (seg)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ------------------------------
	// helpers
	// ------------------------------

	task automatic stop_on_error(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "testbench stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [7:0] act,
	                           input logic [7:0] exp);
		assert (act === exp) else begin
			stop_on_error($sformatf("mismatch %s: expected 0x%02h, actual 0x%02h",
			                        name, exp, act));
		end
	endtask

	// n rising edges, then settle 1 ns
	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	// tens in the upper nibble and units in the lower
	function automatic logic [7:0] bcd_of(input int value);
		logic [3:0] tens;
		logic [3:0] units;
		tens  = 4'(value / 10);
		units = 4'(value % 10);
		return {tens, units};
	endfunction

	// a..g in bits 0..6 and dark for anything but 0..9
	function automatic logic [7:0] segment_pattern(input logic [3:0] d);
		case (d)
			4'd0:    return 8'b0011_1111;
			4'd1:    return 8'b0000_0110;
			4'd2:    return 8'b0101_1011;
			4'd3:    return 8'b0100_1111;
			4'd4:    return 8'b0110_0110;
			4'd5:    return 8'b0110_1101;
			4'd6:    return 8'b0111_1101;
			4'd7:    return 8'b0000_0111;
			4'd8:    return 8'b0111_1111;
			4'd9:    return 8'b0110_1111;
			default: return 8'b0000_0000;
		endcase
	endfunction

	// position i picks field i/2 from seconds up and odd positions are tens
	function automatic logic [3:0] pick_digit(input logic [5:0] s, input logic [7:0] h,
	                                          input logic [7:0] m, input logic [7:0] sc);
		logic [7:0] field;
		logic [3:0] d;
		d = 4'hf;
		for (int i = 0; i < 6; i++) begin
			if (s[i]) begin
				field = (i < 2) ? sc : ((i < 4) ? m : h);
				d = (i % 2 == 1) ? field[7:4] : field[3:0];
			end
		end
		return d;
	endfunction

	// one full scan round checking order and segments per position
	task automatic check_scan();
		logic [5:0] prev;
		logic [5:0] seen;
		prev = '0;
		seen = '0;
		repeat (6 * clock_pkg::SCAN_DIV) begin
			wait_cycles(1);
			assert ($onehot(sel)) else begin
				stop_on_error($sformatf("digit select is not one-hot: 0x%02h", sel));
			end
			if (prev != 6'd0 && sel != prev) begin
				check_value("sel", {2'b00, sel}, {2'b00, prev[4:0], prev[5]});
			end
			check_value("seg", seg, segment_pattern(pick_digit(sel, hour, minute, second)));
			seen = seen | sel;
			prev = sel;
		end
		assert (seen == 6'h3f) else begin
			stop_on_error("scan did not visit all six digit positions");
		end
	endtask

	// ------------------------------
	// timeout
	// ------------------------------

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_limit > 0 && cycle_count > cycle_limit) begin
			$display("timeout: run went past %0d clock cycles", cycle_limit);
			$display("Simulation finished: FAIL");
			$fatal(1, "timeout");
		end
	end

	// ------------------------------
	// main sequence
	// ------------------------------

	initial begin
		rst_n       = 1'b0;
		set_en      = 1'b0;
		set_hours   = '0;
		set_minutes = '0;
		set_seconds = '0;

		fd = $fopen("verif/clock_input.txt", "r");
		if (fd == 0) begin
			stop_on_error("could not open verif/clock_input.txt");
		end
		// comment lines fail the scan and are skipped
		while (!$feof(fd)) begin
			if ($fgets(line, fd) != 0) begin
				if ($sscanf(line, "%d %d %d %d %d %h %h %h",
				            ld, sh, sm, ss, nw, eh, em, es) == 8) begin
					load_q.push_back(ld);
					wait_q.push_back(nw);
					set_h_q.push_back(8'(sh));
					set_m_q.push_back(8'(sm));
					set_s_q.push_back(8'(ss));
					exp_h_q.push_back(8'(eh));
					exp_m_q.push_back(8'(em));
					exp_s_q.push_back(8'(es));
					cycle_limit += nw * int'(clock_pkg::TICK_DIV);
				end
			end
		end
		$fclose(fd);
		cycle_limit += 200;

		// reset, then the readout shows the reset time with a dark display
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;
		check_value("hour", hour, bcd_of(int'(clock_pkg::RST_HOURS)));
		check_value("minute", minute, bcd_of(int'(clock_pkg::RST_MINUTES)));
		check_value("second", second, bcd_of(int'(clock_pkg::RST_SECONDS)));
		check_value("sel", {2'b00, sel}, 8'h00);
		check_value("seg", seg, 8'h00);

		for (int i = 0; i < load_q.size(); i++) begin
			if (load_q[i] != 0) begin
				set_hours   = set_h_q[i];
				set_minutes = set_m_q[i];
				set_seconds = set_s_q[i];
				set_en      = 1'b1;
				wait_cycles(1);
				set_en = 1'b0;
				wait_cycles(wait_q[i] * int'(clock_pkg::TICK_DIV) + 1);
			end else begin
				wait_cycles(wait_q[i] * int'(clock_pkg::TICK_DIV) + 2);
			end
			check_value("hour", hour, exp_h_q[i]);
			check_value("minute", minute, exp_m_q[i]);
			check_value("second", second, exp_s_q[i]);
			steps_run++;
		end

		check_scan();

		if (steps_run > 0) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			$display("no steps found in verif/clock_input.txt");
			$display("Simulation finished: FAIL");
			$fatal(1, "empty data file");
		end
	end

endmodule

/* verilog/clock_top.sv */
/*
  24-hour clock core for a six digit multiplexed display
  bcd readout follows a load by two cycles and a tick by one
  loaded time is not range checked, it must be a valid hh:mm:ss
  sel is zero for the first cycle after reset, seg is dark then
*/

`timescale 1ns/1ps

module clock_top (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             set_en,
	input  clock_pkg::bin_t  set_hours,
	input  clock_pkg::bin_t  set_minutes,
	input  clock_pkg::bin_t  set_seconds,
	output clock_pkg::bcd_t  hour,
	output clock_pkg::bcd_t  minute,
	output clock_pkg::bcd_t  second,
	output clock_pkg::sel_t  sel,
	output clock_pkg::seg_t  seg
);

	// binary time from the counter
	clock_pkg::bin_t hours;
	clock_pkg::bin_t minutes;
	clock_pkg::bin_t seconds;

	// raw select, one cycle ahead of sel
	clock_pkg::sel_t scan_sel;

	time_counter u_time_counter (
		.clk         (clk),
		.rst_n       (rst_n),
		.set_en      (set_en),
		.set_hours   (set_hours),
		.set_minutes (set_minutes),
		.set_seconds (set_seconds),
		.hours       (hours),
		.minutes     (minutes),
		.seconds     (seconds)
	);

	digit_scan u_digit_scan (
		.clk      (clk),
		.rst_n    (rst_n),
		.scan_sel (scan_sel)
	);

	bin_to_bcd u_bin_to_bcd (
		.clk     (clk),
		.rst_n   (rst_n),
		.hours   (hours),
		.minutes (minutes),
		.seconds (seconds),
		.sel_in  (scan_sel),
		.hour    (hour),
		.minute  (minute),
		.second  (second),
		.sel_out (sel)
	);

	// decodes from the registered digits and the delayed select
	seg_decode u_seg_decode (
		.sel    (sel),
		.hour   (hour),
		.minute (minute),
		.second (second),
		.seg    (seg)
	);

endmodule

/* verilog/seg_decode.sv */
/*
  seven-segment decoder for the selected digit, purely combinational
  segments are active high, dp stays off
  a zero or non one-hot select and nibbles 10..15 give a dark digit
*/

`timescale 1ns/1ps

module seg_decode (
	input  clock_pkg::sel_t  sel,
	input  clock_pkg::bcd_t  hour,
	input  clock_pkg::bcd_t  minute,
	input  clock_pkg::bcd_t  second,
	output clock_pkg::seg_t  seg
);

	logic [3:0] digit;

	// ------------------------------
	// digit pick
	// ------------------------------

	always_comb begin
		case (sel)
			6'b000001: digit = second[3:0];
			6'b000010: digit = second[7:4];
			6'b000100: digit = minute[3:0];
			6'b001000: digit = minute[7:4];
			6'b010000: digit = hour[3:0];
			6'b100000: digit = hour[7:4];
			// no digit lit, decodes dark below
			default:   digit = 4'hf;
		endcase
	end

	// ------------------------------
	// segment pattern, dp g f e d c b a
	// ------------------------------

	always_comb begin
		case (digit)
			4'd0:    seg = 8'h3f;
			4'd1:    seg = 8'h06;
			4'd2:    seg = 8'h5b;
			4'd3:    seg = 8'h4f;
			4'd4:    seg = 8'h66;
			4'd5:    seg = 8'h6d;
			4'd6:    seg = 8'h7d;
			4'd7:    seg = 8'h07;
			4'd8:    seg = 8'h7f;
			4'd9:    seg = 8'h6f;
			default: seg = 8'h00;
		endcase
	end

endmodule

/* verilog/digit_scan.sv */
/*
  rotating one-hot select for the six display positions
  each position stays lit for SCAN_DIV cycles, seconds units first
*/

`timescale 1ns/1ps

module digit_scan (
	input  logic             clk,
	input  logic             rst_n,
	output clock_pkg::sel_t  scan_sel
);

	logic [31:0] dwell;
	logic        dwell_end;

	// last cycle on the current digit
	assign dwell_end = (dwell == clock_pkg::SCAN_DIV - 32'd1);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dwell <= '0;
		end else if (dwell_end) begin
			dwell <= '0;
		end else begin
			dwell <= dwell + 32'd1;
		end
	end

	// rotate left, hours tens wraps back to seconds units
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			scan_sel <= 6'b000001;
		end else if (dwell_end) begin
			scan_sel <= {scan_sel[4:0], scan_sel[5]};
		end
	end

endmodule

/* verilog/bin_to_bcd.sv */
/*
  binary to bcd conversion of the three time fields
  a field is converted only when it differs from its held copy,
  so a steady time costs no switching in the adder stages
  readout follows a field change by one cycle, sel_out follows sel_in
  by one cycle to stay lined up with the registered digits
*/

`timescale 1ns/1ps

module bin_to_bcd (
	input  logic             clk,
	input  logic             rst_n,
	input  clock_pkg::bin_t  hours,
	input  clock_pkg::bin_t  minutes,
	input  clock_pkg::bin_t  seconds,
	input  clock_pkg::sel_t  sel_in,
	output clock_pkg::bcd_t  hour,
	output clock_pkg::bcd_t  minute,
	output clock_pkg::bcd_t  second,
	output clock_pkg::sel_t  sel_out
);

	// held copies of the last converted fields
	clock_pkg::bin_t hours_hold;
	clock_pkg::bin_t minutes_hold;
	clock_pkg::bin_t seconds_hold;

	// ------------------------------
	// shift and add 3
	// ------------------------------

	// nbits significant bits, msb first
	// the first three shifts cannot reach 5, so nbits-3 corrections act
	// 5 bits for hours (two steps), 6 bits for minutes and seconds (three)
	function automatic clock_pkg::bcd_t to_bcd(input clock_pkg::bin_t value,
	                                           input int unsigned nbits);
		clock_pkg::bcd_t acc;
		acc = '0;
		for (int i = 5; i >= 0; i--) begin
			if (i < nbits) begin
				// units nibble correction before each shift
				if (acc[3:0] > 4'd4) begin
					acc = acc + 8'd3;
				end
				acc = {acc[6:0], value[i]};
			end
		end
		return acc;
	endfunction

	// ------------------------------
	// change triggered registers
	// ------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hours_hold   <= clock_pkg::RST_HOURS;
			minutes_hold <= clock_pkg::RST_MINUTES;
			seconds_hold <= clock_pkg::RST_SECONDS;
			hour         <= to_bcd(clock_pkg::RST_HOURS, 5);
			minute       <= to_bcd(clock_pkg::RST_MINUTES, 6);
			second       <= to_bcd(clock_pkg::RST_SECONDS, 6);
		end else begin
			if (hours != hours_hold) begin
				hours_hold <= hours;
				hour       <= to_bcd(hours, 5);
			end
			if (minutes != minutes_hold) begin
				minutes_hold <= minutes;
				minute       <= to_bcd(minutes, 6);
			end
			if (seconds != seconds_hold) begin
				seconds_hold <= seconds;
				second       <= to_bcd(seconds, 6);
			end
		end
	end

	// select delayed to match the digit registers
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sel_out <= '0;
		end else begin
			sel_out <= sel_in;
		end
	end

endmodule

/* verilog/time_counter.sv */
/*
  second prescaler and cascaded hh:mm:ss counters
  set_en is a one-cycle strobe and wins over a tick in the same cycle
  loaded values are not range checked, hours must be 0..23 and
  minutes and seconds 0..59, or the counters run out of their range
*/

`timescale 1ns/1ps

module time_counter (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             set_en,
	input  clock_pkg::bin_t  set_hours,
	input  clock_pkg::bin_t  set_minutes,
	input  clock_pkg::bin_t  set_seconds,
	output clock_pkg::bin_t  hours,
	output clock_pkg::bin_t  minutes,
	output clock_pkg::bin_t  seconds
);

	logic [31:0] presc;
	logic        tick;
	logic        sec_wrap;
	logic        min_wrap;

	// ------------------------------
	// prescaler
	// ------------------------------

	// tick in the last cycle of each second
	assign tick = (presc == clock_pkg::TICK_DIV - 32'd1);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			presc <= '0;
		end else if (set_en) begin
			// a load restarts the second
			presc <= '0;
		end else if (tick) begin
			presc <= '0;
		end else begin
			presc <= presc + 32'd1;
		end
	end

	// ------------------------------
	// hh:mm:ss
	// ------------------------------

	// carry conditions
	assign sec_wrap = (seconds == 8'd59);
	assign min_wrap = (minutes == 8'd59);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hours   <= clock_pkg::RST_HOURS;
			minutes <= clock_pkg::RST_MINUTES;
			seconds <= clock_pkg::RST_SECONDS;
		end else if (set_en) begin
			hours   <= set_hours;
			minutes <= set_minutes;
			seconds <= set_seconds;
		end else if (tick) begin
			if (sec_wrap) begin
				seconds <= '0;
				if (min_wrap) begin
					minutes <= '0;
					// 23 -> 00, midnight
					if (hours == 8'd23) begin
						hours <= '0;
					end else begin
						hours <= hours + 8'd1;
					end
				end else begin
					minutes <= minutes + 8'd1;
				end
			end else begin
				seconds <= seconds + 8'd1;
			end
		end
	end

endmodule

/* verilog/clock_pkg.sv */
/*
  shared types and constants of the 24-hour clock core
  TICK_DIV and SCAN_DIV are small so a simulation sees many ticks,
  scale them to the board clock before use in hardware
  reset time is 15:57:34
*/

package clock_pkg;

	// ------------------------------
	// field types
	// ------------------------------

	// binary field, hours 0..23, minutes and seconds 0..59
	typedef logic [7:0] bin_t;

	// two packed bcd digits, tens in [7:4]
	typedef logic [7:0] bcd_t;

	// one-hot digit select
	// bit 0 seconds units up to bit 5 hours tens
	typedef logic [5:0] sel_t;

	// active high segments, [6:0] = g..a, [7] = dp (unused, kept dark)
	typedef logic [7:0] seg_t;

	// ------------------------------
	// timing
	// ------------------------------

	// clock cycles per second tick
	localparam logic [31:0] TICK_DIV = 32'd10;

	// clock cycles each digit stays lit
	localparam logic [31:0] SCAN_DIV = 32'd4;

	// ------------------------------
	// time after reset
	// ------------------------------

	localparam bin_t RST_HOURS   = 8'd15;
	localparam bin_t RST_MINUTES = 8'd57;
	localparam bin_t RST_SECONDS = 8'd34;

endpackage
